//--- project.f
+incdir+common
common/mapper_pkg.sv
src/cfg_regs.sv
src/simple_regs.sv
src/addr_map.sv
mmc3/mmc3_regs.sv
mmc3/scanline_irq.sv
src/cool_mapper_top.sv
tb/mapper_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module mapper_tb -f project.f --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vmapper_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi
exit 0

//--- tb/mapper_tb.sv
`default_nettype none

module mapper_tb;
	import mapper_pkg::*;

	localparam int CYCLE_LIMIT = 4000;     // Far above the summed test lengths

	logic         m2, ppu_addr_in, romsel, cpu_rw, ppu_rd, ppu_wr;
	logic [14:0]  cpu_a;
	logic [7:0]   cpu_d;
	logic [13:0]  ppu_a;
	logic [26:13] cpu_addr_out;
	logic [17:10] ppu_addr_out;
	logic         flash_we, flash_oe, sram_ce, sram_we, sram_oe;
	logic         ppu_rd_out, ppu_wr_out, ppu_ciram_a10, irq_n;

	// Reference model of the mapper state
	logic [12:0]  m_base;
	logic [4:0]   m_cpu_mask, m_chr_mask, m_mapper;
	logic [1:0]   m_sram_page, m_mirror;
	logic [7:0]   m_prg, m_chr, m_latch, m_cnt;
	logic [7:0]   m_r [8];
	logic [2:0]   m_sel;
	logic         m_prg_mode, m_chr_mode, m_lock, m_sram_en, m_prg_wr, m_chr_wr;
	logic         m_reload, m_irq_en, m_irq;

	logic [15:0]  lfsr = 16'd28138;
	int           cycles = 0;
	int           errors = 0;
	int           test_errors = 0;
	int           tests_run = 0;
	int           tests_failed = 0;
	logic         wr_flash_we;               // flash_we seen inside the write cycle

	cool_mapper_top UUT (.*);

	initial
	begin
		m2 = 1'b0;
		forever #2 m2 = ~m2;
	end

	always @(posedge m2)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// CIRAM space never enables CHR reads
	assert property (@(negedge m2) disable iff (ppu_addr_in) !ppu_a[13] || ppu_rd_out)
	else
	begin
		$display("ppu_rd_out was low while ppu_a[13] was set");
		errors++;
		test_errors++;
	end

	// SRAM strobes follow the CPU direction
	assert property (@(negedge m2) disable iff (ppu_addr_in) sram_we == cpu_rw)
	else
	begin
		$display("ERROR sram_we: got %h, expected %h", sram_we, cpu_rw);
		errors++;
		test_errors++;
	end

	assert property (@(negedge m2) disable iff (ppu_addr_in) sram_oe == !cpu_rw)
	else
	begin
		$display("ERROR sram_oe: got %h, expected %h", sram_oe, !cpu_rw);
		errors++;
		test_errors++;
	end

	// Flash output only on ROM reads
	assert property (@(negedge m2) disable iff (ppu_addr_in) flash_oe == !(cpu_rw && !romsel))
	else
	begin
		$display("ERROR flash_oe: got %h, expected %h", flash_oe, !(cpu_rw && !romsel));
		errors++;
		test_errors++;
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // Taps 16 14 13 11
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);                          // One step per bit
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	// 8 KB PRG bank for CPU window win = A14-A13
	function automatic logic [5:0] exp_prg_bank(input logic [1:0] win);
		if (m_mapper == MAP_MMC3)
		begin
			if (win == 2'd1)
				return m_r[7][5:0];
			if (win == 2'd3)
				return 6'h3F;                                 // Last bank
			if (win == (m_prg_mode ? 2'd2 : 2'd0))
				return m_r[6][5:0];
			return 6'h3E;                                     // Second last
		end
		if (m_mapper == MAP_AXROM)
			return {m_prg[3:0], win};
		return {win[1] ? 5'h1F : m_prg[4:0], win[0]};        // UxROM-like
	endfunction

	function automatic logic [13:0] exp_cpu(input logic [1:0] win);
		logic [5:0] m;
		m = exp_prg_bank(win);
		return {m_base | {8'b0, m[5:1] & ~m_cpu_mask}, m[0]};
	endfunction

	// 1 KB CHR slot = PPU A12-A10
	function automatic logic [7:0] exp_ppu(input logic [2:0] slot);
		logic [7:0] b;
		if (m_mapper != MAP_MMC3)
			b = {m_chr[4:0], slot};
		else if (slot[2] == m_chr_mode)
			b = {m_r[slot[1]][7:1], slot[0]};             // 2 KB from R0 or R1
		else
			b = m_r[2 + slot[1:0]];                       // 1 KB from R2-R5
		return {b[7:3] & ~m_chr_mask, b[2:0]};
	endfunction

	function automatic logic exp_ciram(input logic [13:0] pa);
		case (m_mirror)
			2'b00:   return pa[10];
			2'b01:   return pa[11];
			2'b10:   return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("Test %0d %s: %0d errors", tests_run, name, test_errors);
		test_errors = 0;
	endtask

	task automatic reset_model();
		m_base = '0;
		{m_cpu_mask, m_chr_mask, m_mapper, m_sram_page, m_mirror} = '0;
		{m_prg, m_chr, m_latch, m_cnt, m_sel} = '0;
		{m_prg_mode, m_chr_mode, m_lock, m_sram_en, m_prg_wr, m_chr_wr} = '0;
		{m_reload, m_irq_en, m_irq} = '0;
		foreach (m_r[i])
			m_r[i] = '0;
	endtask

	task automatic apply_reset();
		@(posedge m2);
		ppu_addr_in <= 1'b1;
		repeat (4) @(posedge m2);
		ppu_addr_in <= 1'b0;
		@(negedge m2);
		reset_model();
	endtask

	// One CPU write, loaded by the register at the closing edge
	task automatic bus_write(input logic rs, input logic [14:0] a, input logic [7:0] d);
		@(posedge m2);
		romsel <= rs;
		cpu_rw <= 1'b0;
		cpu_a  <= a;
		cpu_d  <= d;
		@(negedge m2);
		wr_flash_we = flash_we;
		@(posedge m2);
		romsel <= 1'b1;                                   // Back to idle
		cpu_rw <= 1'b1;
		cpu_a  <= '0;
		@(negedge m2);
	endtask

	task automatic bus_read(input logic rs, input logic [14:0] a, input logic [13:0] pa);
		@(posedge m2);
		romsel <= rs;
		cpu_rw <= 1'b1;
		cpu_a  <= a;
		ppu_a  <= pa;
		@(negedge m2);
	endtask

	task automatic ppu_cycle(input logic rd, input logic wr, input logic [13:0] pa);
		@(posedge m2);
		ppu_rd <= rd;
		ppu_wr <= wr;
		ppu_a  <= pa;
		@(negedge m2);
	endtask

	// $5xx0-$5xx7 write plus its effect on the model
	task automatic cfg_write(input logic [2:0] off, input logic [7:0] d);
		bus_write(1'b1, 15'h5000 | {12'b0, off}, d);
		if (!m_lock)
		begin
			case (off)
				3'd0: m_base[12:8] = d[4:0];
				3'd1: m_base[7:0] = d;
				3'd2: m_cpu_mask = d[4:0];
				3'd3: m_chr = d;
				3'd4: m_chr_mask = d[4:0];
				3'd5:
				begin
					m_sram_page = d[1:0];
					m_prg = {2'b00, d[7:2]};
				end
				3'd6: m_mapper = d[4:0];
				default:
				begin
					m_lock = d[7];
					m_mirror = d[4:3];
					m_prg_wr = d[2];
					m_chr_wr = d[1];
					m_sram_en = d[0];
				end
			endcase
		end
	endtask

	// $8000-$FFFF write as seen by the current mapper
	task automatic rom_write(input logic [14:0] a, input logic [7:0] d);
		bus_write(1'b0, a, d);
		case (m_mapper)
			MAP_UXROM: m_prg = d;
			MAP_CNROM: m_chr = d;
			MAP_AXROM:
			begin
				m_prg = {3'b000, d[4:0]};
				m_mirror = {1'b1, d[4]};                      // One-screen page
			end
			MAP_MMC3:
			begin
				case ({a[14:13], a[0]})
					3'b000:
					begin
						m_chr_mode = d[7];
						m_prg_mode = d[6];
						m_sel = d[2:0];
					end
					3'b001: m_r[m_sel] = d;
					3'b010: m_mirror = {1'b0, d[0]};
					3'b100: m_latch = d;
					3'b101: m_reload = 1'b1;
					3'b110:
					begin
						m_irq_en = 1'b0;
						m_irq = 1'b0;
					end
					3'b111: m_irq_en = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	endtask

	// A12 already low; after low_cycles it goes high for one cycle
	task automatic a12_pulse(input int low_cycles);
		repeat (low_cycles) @(posedge m2);
		ppu_a[12] <= 1'b1;
		@(posedge m2);                                    // Sampled high here
		ppu_a[12] <= 1'b0;
		@(negedge m2);
	endtask

	task automatic irq_model_rise();
		if (m_reload || m_cnt == 8'd0)
		begin
			m_cnt = m_latch;
			m_reload = 1'b0;
		end
		else
			m_cnt = m_cnt - 8'd1;
		if (m_cnt == 8'd0 && m_irq_en)
			m_irq = 1'b1;
	endtask

	initial
	begin
		int         n, rises;
		logic [7:0] d;
		logic [15:0] rnd;
		logic [13:0] pa;
		logic [4:0] maps [3];
		logic       rs;
		m2_inputs_idle:
		begin
			ppu_addr_in = 1'b1;
			romsel = 1'b1;
			cpu_rw = 1'b1;
			cpu_a = '0;
			cpu_d = '0;
			ppu_rd = 1'b1;
			ppu_wr = 1'b1;
			ppu_a = '0;
		end
		reset_model();
		repeat (4) @(posedge m2);
		ppu_addr_in <= 1'b0;
		@(negedge m2);

		// Configuration and lockout under NROM
		cfg_write(3'd0, rand_bits(5));
		cfg_write(3'd1, rand_bits(8));
		cfg_write(3'd2, rand_bits(5));
		cfg_write(3'd4, rand_bits(5));
		cfg_write(3'd5, rand_bits(8));
		cfg_write(3'd3, rand_bits(8));
		cfg_write(3'd6, 8'(MAP_NROM));
		for (int w = 0; w < 4; w++)
		begin
			bus_read(1'b0, 15'(w << 13), '0);
			check_value("cpu_addr_out", cpu_addr_out, exp_cpu(2'(w)));
		end
		for (int s = 0; s < 8; s++)
		begin
			bus_read(1'b1, '0, 14'(s << 10));
			check_value("ppu_addr_out", ppu_addr_out, exp_ppu(3'(s)));
		end
		cfg_write(3'd7, 8'h80);                           // Lock
		bus_read(1'b0, '0, '0);
		check_value("cpu_addr_out", cpu_addr_out, exp_cpu(2'd0));
		cfg_write(3'd0, {3'b000, ~m_base[12:8]});         // Must be ignored
		bus_read(1'b0, '0, '0);
		check_value("cpu_addr_out", cpu_addr_out, exp_cpu(2'd0));
		end_test("config and lockout");
		apply_reset();                                    // Only reset clears lockout

		// UxROM, CNROM, AxROM
		maps = '{MAP_UXROM, MAP_CNROM, MAP_AXROM};
		cfg_write(3'd1, rand_bits(8));
		cfg_write(3'd4, rand_bits(5));
		for (int k = 0; k < 3; k++)
		begin
			cfg_write(3'd6, {3'b000, maps[k]});
			for (int j = 0; j < 2; j++)
			begin
				d = rand_bits(8);
				if (k == 2)
					d[4] = j[0];                              // Both one-screen pages
				rom_write(15'h0000, d);
				for (int w = 0; w < 4; w++)
				begin
					bus_read(1'b0, 15'(w << 13), '0);
					check_value("cpu_addr_out", cpu_addr_out, exp_cpu(2'(w)));
				end
				pa = {1'b0, 3'(rand_bits(3)), 10'h000};
				bus_read(1'b1, '0, pa);
				check_value("ppu_addr_out", ppu_addr_out, exp_ppu(pa[12:10]));
				check_value("ppu_ciram_a10", ppu_ciram_a10, exp_ciram(pa));
			end
		end
		end_test("simple mappers");

		// MMC3 banking in all four modes
		cfg_write(3'd6, 8'(MAP_MMC3));
		cfg_write(3'd2, rand_bits(5));
		cfg_write(3'd4, rand_bits(5));
		for (int i = 0; i < 8; i++)
		begin
			rom_write(15'h0000, 8'(i));
			rom_write(15'h0001, rand_bits(8));
		end
		for (int mode = 0; mode < 4; mode++)
		begin
			rom_write(15'h0000, {mode[1], mode[0], 6'b000000});
			for (int w = 0; w < 4; w++)
			begin
				bus_read(1'b0, 15'(w << 13), '0);
				check_value("cpu_addr_out", cpu_addr_out, exp_cpu(2'(w)));
			end
			for (int s = 0; s < 8; s++)
			begin
				bus_read(1'b1, '0, 14'(s << 10));
				check_value("ppu_addr_out", ppu_addr_out, exp_ppu(3'(s)));
			end
		end
		for (int v = 0; v < 2; v++)
		begin
			rom_write(15'h2000, 8'(v));                      // Vertical, then horizontal
			for (int s = 0; s < 4; s++)
			begin
				pa = {2'b10, 2'(s), 10'h000};
				bus_read(1'b1, '0, pa);
				check_value("ppu_ciram_a10", ppu_ciram_a10, exp_ciram(pa));
			end
		end
		end_test("mmc3 banking");

		// Scanline IRQ
		bus_read(1'b1, '0, '0);                          // A12 low
		n = 2 + int'(rand_bits(3));
		rom_write(15'h4000, 8'(n));
		rom_write(15'h4001, 8'h00);
		rom_write(15'h6001, 8'h00);
		rises = 0;
		for (int i = 0; i < n + 3 && irq_n === 1'b1; i++)
		begin
			a12_pulse(3);
			rises++;
			irq_model_rise();
			check_value("irq_n", irq_n, !m_irq);
			a12_pulse(2);                                 // Too short to count
			check_value("irq_n", irq_n, !m_irq);
		end
		assert (rises == n + 1)
		else
		begin
			$display("IRQ came after %0d filtered rises instead of %0d", rises, n + 1);
			errors++;
			test_errors++;
		end
		rom_write(15'h6000, 8'h00);                       // Disable and acknowledge
		check_value("irq_n", irq_n, !m_irq);
		end_test("scanline irq");

		// Flash, SRAM and PPU strobes
		cfg_write(3'd6, 8'(MAP_NROM));
		rom_write(15'h0000, 8'h00);
		check_value("flash_we", wr_flash_we, 1'b1);        // Writes still off
		cfg_write(3'd7, 8'h04);
		rom_write(15'h0000, 8'h00);
		check_value("flash_we", wr_flash_we, 1'b0);
		bus_read(1'b0, '0, '0);
		check_value("flash_we", flash_we, 1'b1);
		bus_read(1'b1, 15'h6000, '0);
		check_value("sram_ce", sram_ce, 1'b1);            // SRAM not enabled yet
		cfg_write(3'd5, rand_bits(8));
		cfg_write(3'd7, 8'h05);
		for (int r = 0; r < 8; r++)
		begin
			rs = (r < 4);
			rnd = {rand_bits(5), rand_bits(8)};
			bus_read(rs, {2'(r), rnd[12:0]}, '0);
			check_value("sram_ce", sram_ce, !(rs && r[1:0] == 2'b11 && m_sram_en));
			if (rs)
				check_value("cpu_addr_out", cpu_addr_out, {12'b0, m_sram_page});
		end
		for (int c = 0; c < 2; c++)
		begin
			if (c == 1)
				cfg_write(3'd7, 8'h07);                       // CHR writes on
			for (int i = 0; i < 6; i++)
			begin
				rnd = {8'h00, rand_bits(3)};
				pa = {rnd[2], 3'(rand_bits(3)), 10'h155};
				ppu_cycle(rnd[1], rnd[0], pa);
				check_value("ppu_wr_out", ppu_wr_out, rnd[0] | pa[13] | !m_chr_wr);
				check_value("ppu_rd_out", ppu_rd_out, rnd[1] | pa[13]);
			end
		end
		end_test("memory strobes");

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/cool_mapper_top.sv
`default_nettype none

module cool_mapper_top (
	input  logic        m2,
	input  logic        ppu_addr_in,      // Reset
	input  logic        romsel,           // Low for $8000-$FFFF
	input  logic        cpu_rw,           // Low on write
	input  logic [14:0] cpu_a,
	input  logic [7:0]  cpu_d,
	input  logic        ppu_rd,
	input  logic        ppu_wr,
	input  logic [13:0] ppu_a,
	output logic [26:13] cpu_addr_out,
	output logic        flash_we,
	output logic        flash_oe,
	output logic        sram_ce,
	output logic        sram_we,
	output logic        sram_oe,
	output logic [17:10] ppu_addr_out,
	output logic        ppu_rd_out,
	output logic        ppu_wr_out,
	output logic        ppu_ciram_a10,
	output logic        irq_n
);
	import mapper_pkg::*;

	cpu_base_t  cpu_base;
	bank_mask_t cpu_mask, chr_mask;
	logic [1:0] sram_page;
	mapper_t    mapper;
	mirror_t    mirroring;
	logic       lockout, sram_en, prg_wr_en, chr_wr_en;
	logic [1:0] mir_wr;                  // Bit 0 simple mappers, bit 1 MMC3
	mirror_t    mir_val [2];
	bank_t      chr_bank, prg_bank;
	bank_t      r0, r1, r2, r3, r4, r5, r6, r7;
	logic       prg_mode, chr_mode;
	bank_t      irq_latch;
	logic       irq_reload, irq_enable, irq_disable;

	cfg_regs u_cfg (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .romsel(romsel), .cpu_rw(cpu_rw),
		.cpu_a(cpu_a), .cpu_d(cpu_d), .mir_wr(mir_wr), .mir_val(mir_val),
		.cpu_base(cpu_base), .cpu_mask(cpu_mask), .chr_mask(chr_mask),
		.sram_page(sram_page), .mapper(mapper), .mirroring(mirroring),
		.lockout(lockout), .sram_en(sram_en), .prg_wr_en(prg_wr_en),
		.chr_wr_en(chr_wr_en)
	);

	simple_regs u_simple (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .romsel(romsel), .cpu_rw(cpu_rw),
		.cpu_a(cpu_a), .cpu_d(cpu_d), .mapper(mapper), .lockout(lockout),
		.chr_bank(chr_bank), .prg_bank(prg_bank),
		.mir_wr(mir_wr[0]), .mir_val(mir_val[0])
	);

	mmc3_regs u_mmc3 (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .romsel(romsel), .cpu_rw(cpu_rw),
		.cpu_a(cpu_a), .cpu_d(cpu_d), .mapper(mapper),
		.r0(r0), .r1(r1), .r2(r2), .r3(r3), .r4(r4), .r5(r5), .r6(r6), .r7(r7),
		.prg_mode(prg_mode), .chr_mode(chr_mode),
		.mir_wr(mir_wr[1]), .mir_val(mir_val[1]),
		.irq_latch(irq_latch), .irq_reload(irq_reload),
		.irq_enable(irq_enable), .irq_disable(irq_disable)
	);

	scanline_irq u_irq (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .a12(ppu_a[12]),
		.irq_latch(irq_latch), .irq_reload(irq_reload),
		.irq_enable(irq_enable), .irq_disable(irq_disable), .irq_n(irq_n)
	);

	addr_map u_map (
		.romsel(romsel), .cpu_rw(cpu_rw), .cpu_a(cpu_a),
		.ppu_rd(ppu_rd), .ppu_wr(ppu_wr), .ppu_a(ppu_a),
		.mapper(mapper), .cpu_base(cpu_base), .cpu_mask(cpu_mask),
		.chr_mask(chr_mask), .sram_page(sram_page), .mirroring(mirroring),
		.sram_en(sram_en), .prg_wr_en(prg_wr_en), .chr_wr_en(chr_wr_en),
		.chr_bank(chr_bank), .prg_bank(prg_bank),
		.r0(r0), .r1(r1), .r2(r2), .r3(r3), .r4(r4), .r5(r5), .r6(r6), .r7(r7),
		.prg_mode(prg_mode), .chr_mode(chr_mode),
		.cpu_addr_out(cpu_addr_out), .ppu_addr_out(ppu_addr_out),
		.ppu_ciram_a10(ppu_ciram_a10), .flash_we(flash_we), .flash_oe(flash_oe),
		.sram_ce(sram_ce), .sram_we(sram_we), .sram_oe(sram_oe),
		.ppu_rd_out(ppu_rd_out), .ppu_wr_out(ppu_wr_out)
	);

endmodule

`default_nettype wire

//--- mmc3/scanline_irq.sv
`default_nettype none

`include "mapper_cfg.svh"

module scanline_irq (
	input  logic              m2,
	input  logic              ppu_addr_in,
	input  logic              a12,           // PPU A12, asynchronous to M2
	input  mapper_pkg::bank_t irq_latch,
	input  logic              irq_reload,
	input  logic              irq_enable,
	input  logic              irq_disable,
	output logic              irq_n
);
	import mapper_pkg::*;

	localparam int LOW_W = $clog2(`A12_LOW_CYCLES + 1);

	logic [LOW_W-1:0] low_cnt;     // Saturating run of low samples
	logic             a12_prev;
	logic             a12_rise;    // Filtered rise, one per scanline
	bank_t            counter, counter_next;
	logic             reload_pend, irq_en, irq_flag;

	assign a12_rise = a12 & ~a12_prev & (low_cnt == LOW_W'(`A12_LOW_CYCLES));

	// Reload on request or when empty, else count down
	assign counter_next = (reload_pend || counter == '0) ? irq_latch : counter - 8'd1;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			a12_prev <= 1'b0;
			low_cnt  <= '0;
		end
		else
		begin
			a12_prev <= a12;
			if (a12)
				low_cnt <= '0;
			else if (low_cnt != LOW_W'(`A12_LOW_CYCLES))
				low_cnt <= low_cnt + 1'b1;
		end
	end

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			counter     <= '0;
			reload_pend <= 1'b0;
			irq_en      <= 1'b0;
			irq_flag    <= 1'b0;
		end
		else
		begin
			if (a12_rise)
			begin
				counter <= counter_next;
				if (counter_next == '0 && irq_en)
					irq_flag <= 1'b1;          // Line drops at this same edge
			end
			if (irq_reload)
				reload_pend <= 1'b1;           // New request beats the clear
			else if (a12_rise)
				reload_pend <= 1'b0;
			if (irq_disable)
			begin
				irq_en   <= 1'b0;
				irq_flag <= 1'b0;              // Also acknowledges
			end
			else if (irq_enable)
				irq_en <= 1'b1;
		end
	end

	assign irq_n = ~irq_flag;

endmodule

`default_nettype wire

//--- mmc3/mmc3_regs.sv
`default_nettype none

`include "mapper_cfg.svh"

module mmc3_regs (
	input  logic                m2,
	input  logic                ppu_addr_in,
	input  logic                romsel,
	input  logic                cpu_rw,
	input  logic [14:0]         cpu_a,
	input  logic [7:0]          cpu_d,
	input  mapper_pkg::mapper_t mapper,
	output mapper_pkg::bank_t   r0, r1, r2, r3, r4, r5, r6, r7,
	output logic                prg_mode,
	output logic                chr_mode,
	output logic                mir_wr,
	output mapper_pkg::mirror_t mir_val,
	output mapper_pkg::bank_t   irq_latch,
	output logic                irq_reload,
	output logic                irq_enable,
	output logic                irq_disable
);
	import mapper_pkg::*;

	logic       wr;
	logic [2:0] sel;
	logic [2:0] bank_sel;      // Target of the next $8001 write

	assign wr  = ~cpu_rw & ~romsel & (mapper == MAP_MMC3);
	assign sel = {cpu_a[14:13], cpu_a[0]};

	// Strobes go out in the write cycle itself
	assign mir_wr      = wr & (sel == `MMC3_MIRROR);
	assign mir_val     = cpu_d[0] ? MIR_HORZ : MIR_VERT;
	assign irq_reload  = wr & (sel == `MMC3_IRQ_RELOAD);
	assign irq_disable = wr & (sel == `MMC3_IRQ_OFF);
	assign irq_enable  = wr & (sel == `MMC3_IRQ_ON);

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			bank_sel  <= '0;
			prg_mode  <= 1'b0;
			chr_mode  <= 1'b0;
			irq_latch <= '0;
			{r0, r1, r2, r3} <= '0;
			{r4, r5, r6, r7} <= '0;
		end
		else if (wr && sel == `MMC3_BANK_SEL)
		begin
			chr_mode <= cpu_d[7];      // CHR A12 inversion
			prg_mode <= cpu_d[6];      // Swap $8000 and $C000
			bank_sel <= cpu_d[2:0];
		end
		else if (wr && sel == `MMC3_BANK_DATA)
		begin
			case (bank_sel)
				3'd0:    r0 <= cpu_d;  // 2 KB CHR
				3'd1:    r1 <= cpu_d;
				3'd2:    r2 <= cpu_d;  // 1 KB CHR
				3'd3:    r3 <= cpu_d;
				3'd4:    r4 <= cpu_d;
				3'd5:    r5 <= cpu_d;
				3'd6:    r6 <= cpu_d;  // 8 KB PRG
				default: r7 <= cpu_d;
			endcase
		end
		else if (wr && sel == `MMC3_IRQ_LATCH)
			irq_latch <= cpu_d;
	end

endmodule

`default_nettype wire

//--- src/addr_map.sv
`default_nettype none

`include "mapper_cfg.svh"

module addr_map (
	input  logic                   romsel,
	input  logic                   cpu_rw,
	input  logic [14:0]            cpu_a,
	input  logic                   ppu_rd,
	input  logic                   ppu_wr,
	input  logic [13:0]            ppu_a,
	input  mapper_pkg::mapper_t    mapper,
	input  mapper_pkg::cpu_base_t  cpu_base,
	input  mapper_pkg::bank_mask_t cpu_mask,
	input  mapper_pkg::bank_mask_t chr_mask,
	input  logic [1:0]             sram_page,
	input  mapper_pkg::mirror_t    mirroring,
	input  logic                   sram_en,
	input  logic                   prg_wr_en,
	input  logic                   chr_wr_en,
	input  mapper_pkg::bank_t      chr_bank,
	input  mapper_pkg::bank_t      prg_bank,
	input  mapper_pkg::bank_t      r0, r1, r2, r3, r4, r5, r6, r7,
	input  logic                   prg_mode,
	input  logic                   chr_mode,
	output logic [`CPU_OUT_MSB:`CPU_OUT_LSB] cpu_addr_out,
	output logic [`PPU_OUT_MSB:`PPU_OUT_LSB] ppu_addr_out,
	output logic                   ppu_ciram_a10,
	output logic                   flash_we,
	output logic                   flash_oe,
	output logic                   sram_ce,
	output logic                   sram_we,
	output logic                   sram_oe,
	output logic                   ppu_rd_out,
	output logic                   ppu_wr_out
);
	import mapper_pkg::*;

	logic [18:13] prg_map;       // 8 KB PRG bank before base and mask
	logic [17:10] chr_map;       // 1 KB CHR bank before mask

	always_comb
	begin
		case (mapper)
			MAP_AXROM: prg_map = {prg_bank[3:0], cpu_a[14:13]};     // 32 KB switchable
			MAP_MMC3:
			begin
				case ({cpu_a[14:13], prg_mode})
					3'b000, 3'b101: prg_map = r6[5:0];               // R6 swaps with the fixed bank
					3'b001, 3'b100: prg_map = `MMC3_SECOND_LAST_PRG;
					3'b010, 3'b011: prg_map = r7[5:0];               // $A000 always R7
					default:        prg_map = `MMC3_LAST_PRG;        // $E000 fixed
				endcase
			end
			default: prg_map = {cpu_a[14] ? 5'b11111 : prg_bank[4:0], cpu_a[13]}; // Upper 16 KB fixed
		endcase
	end

	always_comb
	begin
		if (mapper != MAP_MMC3)
			chr_map = {chr_bank[4:0], ppu_a[12:10]};                 // 8 KB bank
		else if (ppu_a[12] == chr_mode)
			chr_map = {ppu_a[11] ? r1[7:1] : r0[7:1], ppu_a[10]};    // 2 KB half
		else
		begin
			case (ppu_a[11:10])
				2'b00:   chr_map = r2;
				2'b01:   chr_map = r3;
				2'b10:   chr_map = r4;
				default: chr_map = r5;
			endcase
		end
	end

	always_comb
	begin
		case (mirroring)
			MIR_VERT:   ppu_ciram_a10 = ppu_a[10];
			MIR_HORZ:   ppu_ciram_a10 = ppu_a[11];
			MIR_ONE_LO: ppu_ciram_a10 = 1'b0;
			default:    ppu_ciram_a10 = 1'b1;
		endcase
	end

	// Flash window for ROM, SRAM page otherwise
	assign cpu_addr_out = ~romsel ?
		{cpu_base | {8'b0, prg_map[18:14] & ~cpu_mask}, prg_map[13]} :
		{12'b0, sram_page};
	assign ppu_addr_out = {chr_map[17:13] & ~chr_mask, chr_map[12:10]};

	assign flash_we   = cpu_rw | romsel | ~prg_wr_en;
	assign flash_oe   = ~cpu_rw | romsel;
	assign sram_ce    = ~(cpu_a[14] & cpu_a[13] & romsel & sram_en);  // $6000-$7FFF
	assign sram_we    = cpu_rw;
	assign sram_oe    = ~cpu_rw;
	assign ppu_rd_out = ppu_rd | ppu_a[13];                           // A13 high is CIRAM
	assign ppu_wr_out = ppu_wr | ppu_a[13] | ~chr_wr_en;              // CHR ROM stays read-only

endmodule

`default_nettype wire

//--- src/simple_regs.sv
`default_nettype none

`include "mapper_cfg.svh"

module simple_regs (
	input  logic                m2,
	input  logic                ppu_addr_in,
	input  logic                romsel,
	input  logic                cpu_rw,
	input  logic [14:0]         cpu_a,
	input  logic [7:0]          cpu_d,
	input  mapper_pkg::mapper_t mapper,
	input  logic                lockout,
	output mapper_pkg::bank_t   chr_bank,
	output mapper_pkg::bank_t   prg_bank,
	output logic                mir_wr,
	output mapper_pkg::mirror_t mir_val
);
	import mapper_pkg::*;

	logic cfg_wr, rom_wr;

	assign cfg_wr = ~cpu_rw & romsel & (cpu_a[14:12] == `CFG_PAGE) & ~lockout;
	assign rom_wr = ~cpu_rw & ~romsel;                  // $8000-$FFFF

	// AxROM picks the one-screen page with D4
	assign mir_wr  = rom_wr & (mapper == MAP_AXROM);
	assign mir_val = cpu_d[4] ? MIR_ONE_HI : MIR_ONE_LO;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			chr_bank <= '0;
			prg_bank <= '0;
		end
		else if (cfg_wr && cpu_a[2:0] == `CFG_CHR_BANK)
			chr_bank <= cpu_d;                          // Direct CHR bank for NROM
		else if (cfg_wr && cpu_a[2:0] == `CFG_SRAM_PRG)
			prg_bank <= {2'b00, cpu_d[7:2]};            // Low bits are the SRAM page
		else if (rom_wr)
		begin
			case (mapper)
				MAP_UXROM: prg_bank <= cpu_d;
				MAP_CNROM: chr_bank <= cpu_d;
				MAP_AXROM: prg_bank <= {3'b000, cpu_d[4:0]};
				default: ;                              // NROM has no bank latch
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/cfg_regs.sv
`default_nettype none

`include "mapper_cfg.svh"

module cfg_regs (
	input  logic                   m2,
	input  logic                   ppu_addr_in,
	input  logic                   romsel,
	input  logic                   cpu_rw,
	input  logic [14:0]            cpu_a,
	input  logic [7:0]             cpu_d,
	input  logic [1:0]             mir_wr,       // One strobe per mapper block
	input  mapper_pkg::mirror_t    mir_val [2],
	output mapper_pkg::cpu_base_t  cpu_base,
	output mapper_pkg::bank_mask_t cpu_mask,
	output mapper_pkg::bank_mask_t chr_mask,
	output logic [1:0]             sram_page,
	output mapper_pkg::mapper_t    mapper,
	output mapper_pkg::mirror_t    mirroring,
	output logic                   lockout,
	output logic                   sram_en,
	output logic                   prg_wr_en,
	output logic                   chr_wr_en
);
	import mapper_pkg::*;

	logic cfg_wr;

	// Write into $5000-$5FFF, ignored once locked
	assign cfg_wr = ~cpu_rw & romsel & (cpu_a[14:12] == `CFG_PAGE) & ~lockout;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			cpu_base  <= '0;
			cpu_mask  <= '0;
			chr_mask  <= '0;
			sram_page <= '0;
			mapper    <= MAP_NROM;
			mirroring <= MIR_VERT;
			lockout   <= 1'b0;
			sram_en   <= 1'b0;
			prg_wr_en <= 1'b0;
			chr_wr_en <= 1'b0;
		end
		else
		begin
			if (cfg_wr)
			begin
				case (cpu_a[2:0])
					`CFG_BASE_HI:  cpu_base[12:8] <= cpu_d[4:0];    // A26-A22
					`CFG_BASE_LO:  cpu_base[7:0]  <= cpu_d;         // A21-A14
					`CFG_CPU_MASK: cpu_mask       <= cpu_d[4:0];
					`CFG_CHR_MASK: chr_mask       <= cpu_d[4:0];
					`CFG_SRAM_PRG: sram_page      <= cpu_d[1:0];    // PRG bits go to simple_regs
					`CFG_MAPPER:   mapper         <= mapper_t'(cpu_d[4:0]);
					`CFG_CTRL:
					begin
						lockout   <= cpu_d[7];                      // Sticky until reset
						mirroring <= mirror_t'(cpu_d[4:3]);
						prg_wr_en <= cpu_d[2];
						chr_wr_en <= cpu_d[1];
						sram_en   <= cpu_d[0];
					end
					default: ;                                      // $5xx3 handled elsewhere
				endcase
			end
			if (mir_wr[1])
				mirroring <= mir_val[1];                            // MMC3 $A000
			else if (mir_wr[0])
				mirroring <= mir_val[0];                            // AxROM page select
		end
	end

endmodule

`default_nettype wire

//--- common/mapper_pkg.sv
`default_nettype none

package mapper_pkg;

	// Mapper number as written to $5xx6
	typedef enum logic [4:0] {
		MAP_NROM  = 5'b00000,   // Also the fallback for unknown codes
		MAP_UXROM = 5'b00001,
		MAP_CNROM = 5'b00010,
		MAP_AXROM = 5'b01000,
		MAP_MMC3  = 5'b10100
	} mapper_t;

	// CIRAM A10 source
	typedef enum logic [1:0] {
		MIR_VERT   = 2'b00,     // PPU A10
		MIR_HORZ   = 2'b01,     // PPU A11
		MIR_ONE_LO = 2'b10,     // One-screen, lower page
		MIR_ONE_HI = 2'b11      // One-screen, upper page
	} mirror_t;

	typedef logic [7:0] bank_t;      // Raw bank register

	// Flash base, bits 26-14 of the flash address
	typedef logic [12:0] cpu_base_t;

	// Mask over A18-A14 on the CPU side, A17-A13 on the CHR side
	typedef logic [4:0] bank_mask_t;

endpackage

`default_nettype wire

//--- common/mapper_cfg.svh
`ifndef MAPPER_CFG_SVH
`define MAPPER_CFG_SVH

// Flash and CHR address windows
`define CPU_OUT_MSB 26
`define CPU_OUT_LSB 13
`define PPU_OUT_MSB 17
`define PPU_OUT_LSB 10

`define A12_LOW_CYCLES 3          // M2 rises A12 must stay low before a rise counts

`define CFG_PAGE 3'b101           // $5000-$5FFF

// Offsets within the config page, address bits 2-0
`define CFG_BASE_HI  3'b000       // $5xx0 base A26-A22
`define CFG_BASE_LO  3'b001       // $5xx1 base A21-A14
`define CFG_CPU_MASK 3'b010       // $5xx2
`define CFG_CHR_BANK 3'b011       // $5xx3
`define CFG_CHR_MASK 3'b100       // $5xx4
`define CFG_SRAM_PRG 3'b101       // $5xx5 SRAM page and PRG bank
`define CFG_MAPPER   3'b110       // $5xx6
`define CFG_CTRL     3'b111       // $5xx7 lockout, mirroring, enables

// MMC3 decode of {A14, A13, A0}
`define MMC3_BANK_SEL   3'b000
`define MMC3_BANK_DATA  3'b001
`define MMC3_MIRROR     3'b010
`define MMC3_IRQ_LATCH  3'b100
`define MMC3_IRQ_RELOAD 3'b101
`define MMC3_IRQ_OFF    3'b110
`define MMC3_IRQ_ON     3'b111

`define MMC3_LAST_PRG        6'b111111
`define MMC3_SECOND_LAST_PRG 6'b111110

`endif
